// ==== design/sysmon_defines.svh ====
// System monitor constants for widths, battery thresholds, telemetry addresses and version
`ifndef SYSMON_DEFINES_SVH
`define SYSMON_DEFINES_SVH

// ADC sample and averaged voltage
`define SM_ADC_W         14
`define SM_SUM_W         22
`define SM_AVG_LOG2      8        // 256 samples per average

// Battery thresholds, AA cells
`define SM_VOLT_VALID    14'd700  // ~1.8 V, below this no battery
`define SM_VOLT_RED      14'd1071 // ~2.8 V

// Menu button debounce
`define SM_DEBOUNCE_LEN  16

// Telemetry framing
`define SM_SYNC_BYTE     8'h5A
`define SM_ADDR_W        7
`define SM_PAYLOAD_W     14
`define SM_ADDR_VOLT     7'd0
`define SM_ADDR_BUTTONS  7'd2
`define SM_ADDR_VERSION  7'd6

// Reserved 2 bits, minor 6, major 18
`define SM_VERSION       14'h0192

`define SM_NUM_CH        3

`endif

// ==== design/sysmon_pkg.sv ====
// Shared system monitor types for the button word, channel requests and frame descriptor
`default_nettype none

`include "sysmon_defines.svh"

package sysmon_pkg;

    // Button word as sent on the buttons channel, MSB first
    typedef struct packed {
        logic menu_closed;
        logic menu_pressed;   // Inverted menu level
        logic down;
        logic left;
        logic right;
        logic up;
        logic a;
        logic b;
        logic sel;
        logic start;
    } buttons_t;

    // One request bit per kept telemetry channel
    typedef logic [`SM_NUM_CH-1:0] ch_req_t;

    typedef logic [$clog2(`SM_NUM_CH)-1:0] ch_sel_t;

    // Channel indices into ch_req_t
    localparam ch_sel_t CH_VOLT    = 2'd0;
    localparam ch_sel_t CH_BUTTONS = 2'd1;
    localparam ch_sel_t CH_VERSION = 2'd2;

    // What packet_tx needs to build one frame
    typedef struct packed {
        logic [`SM_ADDR_W-1:0]    addr;
        logic [`SM_PAYLOAD_W-1:0] payload;
    } pkt_desc_t;

endpackage

`default_nettype wire

// ==== design/menu_control.sv ====
// Menu control: button synchronizers, menu button debounce and menu open/close toggle
`default_nettype none

`include "sysmon_defines.svh"

module menu_control (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 btn_menu,   // Pressed = 0
    input  logic                 btn_a,
    input  logic                 btn_b,
    input  logic                 btn_up,
    input  logic                 btn_down,
    input  logic                 btn_left,
    input  logic                 btn_right,
    input  logic                 btn_sel,
    input  logic                 btn_start,
    output sysmon_pkg::buttons_t buttons,
    output logic                 menu_closed
);
    import sysmon_pkg::*;

    localparam int HIST_LEN = `SM_DEBOUNCE_LEN;
    localparam logic [HIST_LEN-1:0] PRESS_PAT   = {1'b1, {(HIST_LEN-1){1'b0}}};
    localparam logic [HIST_LEN-1:0] RELEASE_PAT = ~PRESS_PAT;

    logic [8:0]          btn_raw;
    logic [8:0]          btn_meta;
    logic [8:0]          btn_sync;
    logic [HIST_LEN-1:0] menu_hist;
    logic                menu_armed;   // Clean press seen, no other button yet
    logic                others_high;

    // Menu on bit 8, the rest in buttons_t order
    assign btn_raw = {btn_menu, btn_down, btn_left, btn_right, btn_up,
                      btn_a, btn_b, btn_sel, btn_start};
    assign others_high = |btn_sync[7:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            btn_meta <= 9'h100;   // Menu idles high
            btn_sync <= 9'h100;
        end else begin
            btn_meta <= btn_raw;
            btn_sync <= btn_meta;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            menu_hist   <= '1;
            menu_armed  <= 1'b0;
            menu_closed <= 1'b1;
        end else begin
            menu_hist <= {menu_hist[HIST_LEN-2:0], btn_sync[8]};
            if (menu_hist == PRESS_PAT) begin
                menu_armed <= 1'b1;
            end else if (menu_hist == RELEASE_PAT && menu_armed && !others_high) begin
                menu_armed  <= 1'b0;
                menu_closed <= ~menu_closed;
            end
            if (others_high) begin
                menu_armed <= 1'b0;   // Chord, not a menu press
            end
        end
    end

    always_comb begin
        buttons.menu_closed  = menu_closed;
        buttons.menu_pressed = ~btn_sync[8];
        buttons.down         = btn_sync[7];
        buttons.left         = btn_sync[6];
        buttons.right        = btn_sync[5];
        buttons.up           = btn_sync[4];
        buttons.a            = btn_sync[3];
        buttons.b            = btn_sync[2];
        buttons.sel          = btn_sync[1];
        buttons.start        = btn_sync[0];
    end

    // Menu state only moves right after a debounced release
    assert property (@(posedge clk) disable iff (reset)
        $changed(menu_closed) |-> $past(menu_hist) == RELEASE_PAT);

endmodule

`default_nettype wire

// ==== design/battery_monitor.sv ====
// Battery monitor: averages ADC samples into a voltage, flags low battery and blinks the red LED
`default_nettype none

`include "sysmon_defines.svh"

module battery_monitor (
    input  logic                clk,
    input  logic                reset,
    input  logic                adc_ready,
    input  logic                second_tick,
    input  logic                charging,
    input  logic [`SM_ADC_W-1:0] adc_value,
    output logic [`SM_ADC_W-1:0] volt,
    output logic                volt_new,
    output logic                low_battery,
    output logic                led_red
);

    localparam int CNT_W = `SM_AVG_LOG2 + 1;
    localparam logic [CNT_W-1:0] WINDOW = CNT_W'(1) << `SM_AVG_LOG2;

    logic [`SM_SUM_W-1:0] volt_sum;
    logic [`SM_SUM_W-1:0] sample_ext;
    logic [CNT_W-1:0]     volt_cnt;
    logic                 avg_full;
    logic                 blink;

    assign sample_ext = {{(`SM_SUM_W-`SM_ADC_W){1'b0}}, adc_value};
    assign avg_full   = volt_cnt[CNT_W-1];   // 256 samples in

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            volt_sum <= '0;
            volt_cnt <= '0;
            volt     <= '0;
            volt_new <= 1'b0;
        end else begin
            volt_new <= 1'b0;
            if (avg_full) begin
                volt     <= volt_sum[`SM_AVG_LOG2 +: `SM_ADC_W];
                volt_new <= 1'b1;
                // Keep a sample landing on the publish cycle
                if (adc_ready) begin
                    volt_sum <= sample_ext;
                    volt_cnt <= CNT_W'(1);
                end else begin
                    volt_sum <= '0;
                    volt_cnt <= '0;
                end
            end else if (adc_ready) begin
                volt_sum <= volt_sum + sample_ext;
                volt_cnt <= volt_cnt + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            low_battery <= 1'b0;
            blink       <= 1'b0;
        end else begin
            low_battery <= (volt >= `SM_VOLT_VALID) && (volt < `SM_VOLT_RED) && !charging;
            if (second_tick) begin
                blink <= ~blink;
            end
        end
    end

    assign led_red = low_battery & blink;

    // Sample window never runs past 256 samples
    assert property (@(posedge clk) disable iff (reset)
        volt_cnt <= WINDOW);

endmodule

`default_nettype wire

// ==== design/channel_arbiter.sv ====
// Channel arbiter: latches telemetry requests and grants them round-robin, one frame at a time
`default_nettype none

`include "sysmon_defines.svh"

module channel_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  sysmon_pkg::ch_req_t req,
    input  logic                done,
    output logic                start,
    output sysmon_pkg::ch_sel_t sel
);
    import sysmon_pkg::*;

    ch_req_t pending;
    ch_req_t done_mask;
    ch_sel_t pick;
    logic    pick_val;
    logic    busy;   // Frame in flight

    always_comb begin
        done_mask = '0;
        if (done) begin
            done_mask[sel] = 1'b1;
        end
    end

    // Lowest pending index above the last grant; sel holds the last grant
    always_comb begin
        int idx;
        pick     = sel;
        pick_val = 1'b0;
        for (int off = `SM_NUM_CH; off >= 1; off--) begin
            idx = (int'(sel) + off) % `SM_NUM_CH;
            if (pending[idx]) begin
                pick     = ch_sel_t'(idx);
                pick_val = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= '0;
            busy    <= 1'b0;
            start   <= 1'b0;
            sel     <= ch_sel_t'(`SM_NUM_CH - 1);   // Channel 0 goes first
        end else begin
            pending <= (pending & ~done_mask) | req;
            start   <= 1'b0;
            if (done) begin
                busy <= 1'b0;
            end else if (!busy && pick_val) begin
                start <= 1'b1;
                sel   <= pick;
                busy  <= 1'b1;
            end
        end
    end

    // Transmitter only reports done for a frame that was granted
    assert property (@(posedge clk) disable iff (reset)
        done |-> busy);

endmodule

`default_nettype wire

// ==== design/packet_tx.sv ====
// Packet transmitter: builds the five-byte frame of a granted channel and paces it on UART busy
`default_nettype none

`include "sysmon_defines.svh"

module packet_tx (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  sysmon_pkg::ch_sel_t  sel,
    input  logic [`SM_ADC_W-1:0] volt,
    input  sysmon_pkg::buttons_t buttons,
    input  logic                 uart_tx_busy,
    output logic [7:0]           uart_tx_data,
    output logic                 uart_tx_val,
    output logic                 done
);
    import sysmon_pkg::*;

    localparam int FRAME_LEN = 5;   // Sync, address, count, high, low

    pkt_desc_t  desc_in;
    pkt_desc_t  desc;
    logic       active;
    logic       hold;   // Gap cycle so a fresh busy is seen
    logic       send;
    logic [2:0] byte_idx;
    logic [7:0] next_byte;

    always_comb begin
        case (sel)
            CH_VOLT: begin
                desc_in.addr    = `SM_ADDR_VOLT;
                desc_in.payload = volt;
            end
            CH_BUTTONS: begin
                desc_in.addr    = `SM_ADDR_BUTTONS;
                desc_in.payload = {{(`SM_PAYLOAD_W-$bits(buttons_t)){1'b0}}, buttons};
            end
            default: begin
                desc_in.addr    = `SM_ADDR_VERSION;
                desc_in.payload = `SM_VERSION;
            end
        endcase
    end

    // Payload frozen for the whole frame
    always_ff @(posedge clk) begin
        if (start) begin
            desc <= desc_in;
        end
    end

    always_comb begin
        case (byte_idx)
            3'd0:    next_byte = `SM_SYNC_BYTE;
            3'd1:    next_byte = {1'b0, desc.addr};
            3'd2:    next_byte = 8'd2;   // Payload byte count
            3'd3:    next_byte = {2'b00, desc.payload[`SM_PAYLOAD_W-1:8]};
            default: next_byte = desc.payload[7:0];
        endcase
    end

    assign send = active && !hold && !uart_tx_busy;

    always_ff @(posedge clk) begin
        if (send) begin
            uart_tx_data <= next_byte;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active      <= 1'b0;
            hold        <= 1'b0;
            byte_idx    <= '0;
            uart_tx_val <= 1'b0;
            done        <= 1'b0;
        end else begin
            uart_tx_val <= 1'b0;
            done        <= 1'b0;
            hold        <= 1'b0;
            if (start) begin
                active   <= 1'b1;
                byte_idx <= '0;
            end else if (send) begin
                uart_tx_val <= 1'b1;
                hold        <= 1'b1;
                if (byte_idx == 3'(FRAME_LEN - 1)) begin
                    done   <= 1'b1;   // Lines up with the last byte
                    active <= 1'b0;
                end else begin
                    byte_idx <= byte_idx + 3'd1;
                end
            end
        end
    end

    // The UART must be idle whenever a byte is handed over
    assert property (@(posedge clk) disable iff (reset)
        uart_tx_val |-> !uart_tx_busy);

endmodule

`default_nettype wire

// ==== design/system_monitor.sv ====
// System monitor top: menu and battery producers feeding the telemetry arbiter and UART framer
`default_nettype none

`include "sysmon_defines.svh"

module system_monitor (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 btn_menu,   // Pressed = 0
    input  logic                 btn_a,
    input  logic                 btn_b,
    input  logic                 btn_up,
    input  logic                 btn_down,
    input  logic                 btn_left,
    input  logic                 btn_right,
    input  logic                 btn_sel,
    input  logic                 btn_start,
    input  logic                 adc_ready,
    input  logic [`SM_ADC_W-1:0] adc_value,
    input  logic                 charging,
    input  logic                 second_tick,
    input  logic                 uart_tx_busy,
    output logic                 menu_closed,
    output logic                 low_battery,
    output logic                 led_red,
    output logic [7:0]           uart_tx_data,
    output logic                 uart_tx_val
);
    import sysmon_pkg::*;

    buttons_t             buttons;
    logic [`SM_ADC_W-1:0] volt;
    logic                 volt_new;
    ch_req_t              req;
    logic                 tx_start;
    ch_sel_t              tx_sel;
    logic                 tx_done;

    // Telemetry only streams while the menu is open
    always_comb begin
        req             = '0;
        req[CH_VOLT]    = ~menu_closed & volt_new;
        req[CH_BUTTONS] = ~menu_closed;
        req[CH_VERSION] = ~menu_closed;
    end

    menu_control menu_control_inst (
        .clk         (clk),
        .reset       (reset),
        .btn_menu    (btn_menu),
        .btn_a       (btn_a),
        .btn_b       (btn_b),
        .btn_up      (btn_up),
        .btn_down    (btn_down),
        .btn_left    (btn_left),
        .btn_right   (btn_right),
        .btn_sel     (btn_sel),
        .btn_start   (btn_start),
        .buttons     (buttons),
        .menu_closed (menu_closed)
    );

    battery_monitor battery_monitor_inst (
        .clk         (clk),
        .reset       (reset),
        .adc_ready   (adc_ready),
        .second_tick (second_tick),
        .charging    (charging),
        .adc_value   (adc_value),
        .volt        (volt),
        .volt_new    (volt_new),
        .low_battery (low_battery),
        .led_red     (led_red)
    );

    channel_arbiter channel_arbiter_inst (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .done  (tx_done),
        .start (tx_start),
        .sel   (tx_sel)
    );

    packet_tx packet_tx_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (tx_start),
        .sel          (tx_sel),
        .volt         (volt),
        .buttons      (buttons),
        .uart_tx_busy (uart_tx_busy),
        .uart_tx_data (uart_tx_data),
        .uart_tx_val  (uart_tx_val),
        .done         (tx_done)
    );

endmodule

`default_nettype wire

// ==== verif/tb_system_monitor.sv ====
// Testbench for the system monitor with table-driven stimulus, a UART busy model and a frame decoder
`default_nettype none

module tb_system_monitor;
    timeunit 1ns;
    timeprecision 1ps;

    import sysmon_pkg::*;

    typedef struct packed {
        logic        menu_row;   // Menu press/release, else a voltage step
        logic        hold_a;
        logic [13:0] adc;
        logic        chg;
        logic [1:0]  ticks;
        logic        exp_closed;
        logic        exp_low;
    } row_t;

    localparam int NUM_ROWS = 10;
    localparam int WAIT_LIMIT = 3000;
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b1, 1'b0, 14'd0,    1'b0, 2'd0, 1'b0, 1'b0},   // Open menu
        '{1'b1, 1'b1, 14'd0,    1'b0, 2'd0, 1'b0, 1'b0},   // Chord with A, no toggle
        '{1'b0, 1'b0, 14'd1500, 1'b0, 2'd1, 1'b0, 1'b0},
        '{1'b0, 1'b0, 14'd900,  1'b0, 2'd0, 1'b0, 1'b1},
        '{1'b0, 1'b0, 14'd900,  1'b1, 2'd1, 1'b0, 1'b0},
        '{1'b0, 1'b0, 14'd650,  1'b0, 2'd1, 1'b0, 1'b0},   // Below valid, no battery
        '{1'b0, 1'b0, 14'd650,  1'b1, 2'd0, 1'b0, 1'b0},
        '{1'b0, 1'b0, 14'd1500, 1'b1, 2'd1, 1'b0, 1'b0},
        '{1'b0, 1'b0, 14'd900,  1'b0, 2'd2, 1'b0, 1'b1},
        '{1'b1, 1'b0, 14'd0,    1'b0, 2'd0, 1'b1, 1'b0}    // Close menu
    };

    logic        clk = 1'b0;
    logic        reset;
    logic        btn_menu, btn_a, btn_b, btn_up, btn_down;
    logic        btn_left, btn_right, btn_sel, btn_start;
    logic        adc_ready;
    logic [13:0] adc_value;
    logic        charging;
    logic        second_tick;
    logic        uart_tx_busy = 1'b0;
    logic        menu_closed, low_battery, led_red;
    logic [7:0]  uart_tx_data;
    logic        uart_tx_val;

    int          error_count = 0;
    int          cycles = 0;
    int          samples_sent = 0;
    int          ticks_sent = 0;
    int          busy_left = 0;
    int          bytes_seen = 0;
    int          last_byte_cycle = 0;
    int          frame_count = 0;
    int          volt_frames = 0;
    int          buttons_frames = 0;
    int          version_frames = 0;
    logic [13:0] last_volt;
    logic [7:0]  frame [5];
    int          byte_pos = 0;
    int          prev_ch = 0;
    logic        rr_valid = 1'b0;
    logic        quiet = 1'b0;   // No button activity can reach a frame
    buttons_t    exp_buttons;

    always #5 clk = ~clk;

    system_monitor system_monitor_inst (
        .clk          (clk),
        .reset        (reset),
        .btn_menu     (btn_menu),
        .btn_a        (btn_a),
        .btn_b        (btn_b),
        .btn_up       (btn_up),
        .btn_down     (btn_down),
        .btn_left     (btn_left),
        .btn_right    (btn_right),
        .btn_sel      (btn_sel),
        .btn_start    (btn_start),
        .adc_ready    (adc_ready),
        .adc_value    (adc_value),
        .charging     (charging),
        .second_tick  (second_tick),
        .uart_tx_busy (uart_tx_busy),
        .menu_closed  (menu_closed),
        .low_battery  (low_battery),
        .led_red      (led_red),
        .uart_tx_data (uart_tx_data),
        .uart_tx_val  (uart_tx_val)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("=== FAIL ===");
        $fatal(1, {"timed out waiting for ", what});
    endtask

    // UART busy for 1 to 6 cycles after every byte
    always @(posedge clk) begin
        if (uart_tx_val) begin
            busy_left = 1 + int'($urandom % 6);
        end else if (busy_left > 0) begin
            busy_left--;
        end
        #1;
        uart_tx_busy = (busy_left > 0);
    end

    task automatic finish_frame();
        logic [13:0] payload;
        int          ch;
        payload = {frame[3][5:0], frame[4]};
        case (frame[1])
            8'd0:    ch = 0;
            8'd2:    ch = 1;
            8'd6:    ch = 2;
            default: ch = -1;
        endcase
        check_value("frame address is a kept channel", ch >= 0, 1);
        frame_count++;
        case (ch)
            0: begin
                volt_frames++;
                last_volt = payload;
            end
            1: begin
                buttons_frames++;
                check_value("buttons payload bits 13:10", payload[13:10], 4'h0);
                if (quiet) begin
                    check_value("buttons payload", payload, {4'h0, exp_buttons});
                end
            end
            default: begin
                version_frames++;
                check_value("version high byte", frame[3], 8'h01);
                check_value("version low byte", frame[4], 8'h92);
            end
        endcase
        if (rr_valid) begin
            if (prev_ch == 2) begin
                check_value("channel after version is not version", ch != 2, 1);
            end else begin
                check_value("round-robin channel", ch, prev_ch + 1);
            end
        end
        prev_ch  = ch;
        rr_valid = 1'b1;
    endtask

    // Frame decoder
    always @(posedge clk) begin
        cycles++;
        if (!reset) begin
            if (menu_closed) begin
                rr_valid = 1'b0;   // Order only holds while requests flow
            end
            if (uart_tx_val) begin
                check_value("uart_tx_busy at uart_tx_val", uart_tx_busy, 1'b0);
                bytes_seen++;
                last_byte_cycle = cycles;
                frame[byte_pos] = uart_tx_data;
                case (byte_pos)
                    0:       check_value("sync byte", uart_tx_data, 8'h5A);
                    2:       check_value("byte count", uart_tx_data, 8'd2);
                    3:       check_value("payload high bits 7:6", uart_tx_data[7:6], 2'b00);
                    default: ;
                endcase
                if (byte_pos == 4) begin
                    finish_frame();
                    byte_pos = 0;
                end else begin
                    byte_pos++;
                end
            end
        end
    end

    task automatic send_sample(input logic [13:0] value);
        int gap;
        gap = int'($urandom % 4);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #1;
        adc_value = value;
        adc_ready = 1'b1;
        @(posedge clk);
        #1;
        adc_ready = 1'b0;
        samples_sent++;
    endtask

    // Finish the open window, then one full window of the value
    task automatic publish_average(input logic [13:0] value);
        int fill;
        fill = (256 - (samples_sent % 256)) % 256;
        repeat (fill) send_sample(value);
        repeat (256) send_sample(value);
    endtask

    task automatic pulse_tick();
        @(posedge clk);
        #1;
        second_tick = 1'b1;
        @(posedge clk);
        #1;
        second_tick = 1'b0;
        ticks_sent++;
    endtask

    task automatic press_menu(input logic hold_a);
        @(posedge clk);
        #1;
        btn_menu = 1'b0;
        btn_a    = hold_a;
        repeat (20) @(posedge clk);
        #1;
        btn_menu = 1'b1;
        btn_a    = 1'b0;
        repeat (20) @(posedge clk);
        #1;
    endtask

    task automatic wait_frames(input int n);
        int target;
        int waited;
        target = frame_count + n;
        waited = 0;
        while (frame_count < target) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("telemetry frames");
        end
    endtask

    task automatic wait_volt_frame(input int seen);
        int waited;
        waited = 0;
        while (volt_frames <= seen) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("a voltage frame");
        end
    endtask

    task automatic wait_idle(input int gap);
        int waited;
        waited = 0;
        while (cycles - last_byte_cycle < gap) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("the UART stream to go idle");
        end
    endtask

    initial begin
        row_t row;
        int   start_cycle;
        int   vcount;
        int   bytes_before;
        int   buttons_before;
        int   version_before;
        void'($urandom(32'h0ba12f13));
        reset       = 1'b1;
        btn_menu    = 1'b1;   // Released
        btn_a       = 1'b0;
        btn_b       = 1'b0;
        btn_up      = 1'b0;
        btn_down    = 1'b0;
        btn_left    = 1'b0;
        btn_right   = 1'b0;
        btn_sel     = 1'b0;
        btn_start   = 1'b0;
        adc_ready   = 1'b0;
        adc_value   = '0;
        charging    = 1'b0;
        second_tick = 1'b0;
        exp_buttons = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("menu_closed after reset", menu_closed, 1'b1);

        start_cycle = cycles;
        while (cycles - start_cycle < 2000) send_sample(14'd1500);
        check_value("bytes while menu closed", bytes_seen, 0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = ROWS[r];
            if (row.menu_row) begin
                quiet = 1'b0;
                btn_b = 1'b0;
                press_menu(row.hold_a);
                check_value("menu_closed", menu_closed, row.exp_closed);
                if (!row.exp_closed) begin
                    btn_b         = row.hold_a;   // B stays held after the chord row
                    exp_buttons   = '0;
                    exp_buttons.b = row.hold_a;
                    wait_frames(2);   // Frames built during the press are gone
                    quiet = 1'b1;
                    buttons_before = buttons_frames;
                    version_before = version_frames;
                    wait_frames(3);
                    check_value("buttons frames seen", buttons_frames > buttons_before, 1);
                    check_value("version frames seen", version_frames > version_before, 1);
                end
            end else begin
                charging = row.chg;
                repeat (row.ticks) pulse_tick();
                publish_average(row.adc);
                vcount = volt_frames;
                repeat (3) @(posedge clk);
                #1;
                check_value("low_battery", low_battery, row.exp_low);
                check_value("led_red", led_red, row.exp_low & (ticks_sent % 2 == 1));
                wait_volt_frame(vcount);
                check_value("voltage payload", last_volt, row.adc);
            end
        end

        // Pending frames drain, then the stream stays silent
        wait_idle(100);
        bytes_before = bytes_seen;
        publish_average(14'd900);
        wait_idle(100);
        check_value("bytes after menu closed", bytes_seen, bytes_before);

        if (error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/sysmon_pkg.sv
design/menu_control.sv
design/battery_monitor.sv
design/channel_arbiter.sv
design/packet_tx.sv
design/system_monitor.sv
verif/tb_system_monitor.sv

// ==== Makefile ====
# Verilator build and run for the system monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_system_monitor
BUILD_DIR ?= build
SEED      ?= 1
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(wildcard design/*.sv design/*.svh verif/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): list.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f

run: compile
	$(BINARY) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)
